// File: source/alu_pkg.sv
package alu_pkg;

    // ####################################################################
    // Widths
    // ####################################################################

    localparam int DATA_W     = 16;
    localparam int REG_ADDR_W = 4;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;
    localparam int CMD_W      = 32;

    localparam int ARITH_PAD_W = CMD_W - 2 - 3 * REG_ADDR_W;
    localparam int IMM_PAD_W   = CMD_W - 2 - REG_ADDR_W - DATA_W;

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,  // result.data = rA
        OP_WRITE = 2'd1,  // rA = imm
        OP_ADD   = 2'd2,  // rR = rA + rB
        OP_SUB   = 2'd3   // rR = rA - rB
    } op_t;

    // ####################################################################
    // Command word in two layouts
    // ####################################################################

    typedef struct packed {
        op_t                    op;
        logic [REG_ADDR_W-1:0]  addr_r;
        logic [REG_ADDR_W-1:0]  addr_b;
        logic [REG_ADDR_W-1:0]  addr_a;
        logic [ARITH_PAD_W-1:0] pad;
    } cmd_arith_t;

    typedef struct packed {
        op_t                   op;
        logic [IMM_PAD_W-1:0]  pad;
        logic [REG_ADDR_W-1:0] addr_a;
        logic [DATA_W-1:0]     data;
    } cmd_imm_t;

    typedef union packed {
        cmd_arith_t arith;  // READ, ADD, SUB
        cmd_imm_t   imm;    // WRITE
    } cmd_u;

    typedef struct packed {
        logic [DATA_W-1:0] data;   // Last READ value
        logic              carry;  // Carry out of last ADD/SUB
        logic              busy;
    } result_t;

    // APB byte addresses
    localparam logic [3:0] ADDR_CMD    = 4'h0;
    localparam logic [3:0] ADDR_RESULT = 4'h4;
    localparam logic [3:0] ADDR_STATUS = 4'h8;

endpackage

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [alu_pkg::REG_ADDR_W-1:0] rd0_addr,
    input  logic [alu_pkg::REG_ADDR_W-1:0] rd1_addr,
    input  logic [alu_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic                           wr_en,
    input  logic [alu_pkg::DATA_W-1:0]     wr_data,
    output logic [alu_pkg::DATA_W-1:0]     rd0_data,
    output logic [alu_pkg::DATA_W-1:0]     rd1_data
);

    logic [alu_pkg::DATA_W-1:0] regs [alu_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < alu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // ####################################################################
    // Write-through reads
    // ####################################################################

    // Same-cycle write wins, so a dependent command sees the new value
    always_comb begin
        if (wr_en && (wr_addr == rd0_addr)) begin
            rd0_data = wr_data;
        end else begin
            rd0_data = regs[rd0_addr];
        end
    end

    always_comb begin
        if (wr_en && (wr_addr == rd1_addr)) begin
            rd1_data = wr_data;
        end else begin
            rd1_data = regs[rd1_addr];
        end
    end

endmodule

// File: source/alu_registers.sv
`timescale 1ns/1ps

module alu_registers (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_valid,
    input  alu_pkg::cmd_u    cmd,
    output logic             cmd_ready,
    output alu_pkg::result_t result
);

    logic pop;

    // Register file ports
    logic [alu_pkg::REG_ADDR_W-1:0] rd0_addr;
    logic [alu_pkg::REG_ADDR_W-1:0] rd1_addr;
    logic [alu_pkg::DATA_W-1:0]     rd0_data;
    logic [alu_pkg::DATA_W-1:0]     rd1_data;
    logic [alu_pkg::REG_ADDR_W-1:0] wr_addr;
    logic                           wr_en;
    logic [alu_pkg::DATA_W-1:0]     wr_data;

    // Stage 1 registers
    logic                           s1_valid;
    alu_pkg::op_t                   s1_op;
    logic [alu_pkg::REG_ADDR_W-1:0] s1_dest;
    logic [alu_pkg::DATA_W-1:0]     s1_a;
    logic [alu_pkg::DATA_W-1:0]     s1_b;  // Operand B or immediate

    // Stage 2 arithmetic
    logic                           sub;
    logic [alu_pkg::DATA_W-1:0]     b_eff;
    logic [alu_pkg::DATA_W:0]       sum;

    logic [alu_pkg::DATA_W-1:0]     res_data;
    logic                           res_carry;

    assign cmd_ready = 1'b1;
    assign pop       = cmd_valid && cmd_ready;

    register_file u_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd0_addr (rd0_addr),
        .rd1_addr (rd1_addr),
        .wr_addr  (wr_addr),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd0_data (rd0_data),
        .rd1_data (rd1_data)
    );

    // ####################################################################
    // Stage 1 decode and operand fetch
    // ####################################################################

    assign rd0_addr = cmd.arith.addr_a;
    assign rd1_addr = cmd.arith.addr_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            s1_op <= cmd.arith.op;  // Same bits in both views
            s1_a  <= rd0_data;
            if (cmd.arith.op == alu_pkg::OP_WRITE) begin
                s1_dest <= cmd.imm.addr_a;
                s1_b    <= cmd.imm.data;
            end else begin
                s1_dest <= cmd.arith.addr_r;
                s1_b    <= rd1_data;
            end
        end
    end

    // ####################################################################
    // Stage 2 execute and writeback
    // ####################################################################

    assign sub   = (s1_op == alu_pkg::OP_SUB);
    assign b_eff = sub ? ~s1_b : s1_b;
    assign sum   = {1'b0, s1_a} + {1'b0, b_eff} + (alu_pkg::DATA_W+1)'(sub);

    assign wr_en   = s1_valid && (s1_op != alu_pkg::OP_READ);
    assign wr_addr = s1_dest;
    assign wr_data = (s1_op == alu_pkg::OP_WRITE) ? s1_b : sum[alu_pkg::DATA_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_data  <= '0;
            res_carry <= 1'b0;
        end else if (s1_valid) begin
            case (s1_op)
                alu_pkg::OP_READ: res_data <= s1_a;
                alu_pkg::OP_ADD,
                alu_pkg::OP_SUB:  res_carry <= sum[alu_pkg::DATA_W];
                default: ;
            endcase
        end
    end

    assign result.data  = res_data;
    assign result.carry = res_carry;
    assign result.busy  = cmd_valid || s1_valid;

endmodule

// File: source/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          push,
    input  alu_pkg::cmd_u push_data,
    input  logic          cmd_ready,
    output logic          full,
    output logic          cmd_valid,
    output alu_pkg::cmd_u cmd
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    alu_pkg::cmd_u mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;
    logic             do_push;

    assign full      = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign cmd_valid = (count != '0);
    assign cmd       = mem[rd_ptr];

    assign pop     = cmd_valid && cmd_ready;
    assign do_push = push && (!full || pop);  // Full is fine if a slot frees now

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/apb_cmd_slave.sv
`timescale 1ns/1ps

module apb_cmd_slave (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [3:0]            paddr,
    input  logic [31:0]           pwdata,
    input  logic                  full,
    input  alu_pkg::result_t      result,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  push,
    output alu_pkg::cmd_u         push_data
);

    logic setup_phase;
    logic access_phase;
    logic addr_cmd;
    logic addr_result;
    logic addr_status;
    logic mapped;
    logic cmd_write;
    logic bad_access;
    logic [31:0] read_word;

    assign setup_phase  = psel && !penable;
    assign access_phase = psel && penable;

    assign addr_cmd    = (paddr == alu_pkg::ADDR_CMD);
    assign addr_result = (paddr == alu_pkg::ADDR_RESULT);
    assign addr_status = (paddr == alu_pkg::ADDR_STATUS);
    assign mapped      = addr_cmd || addr_result || addr_status;

    assign cmd_write = pwrite && addr_cmd;

    // Unmapped, or a write to a read-only register
    assign bad_access = !mapped || (pwrite && !addr_cmd);

    // ####################################################################
    // Handshake
    // ####################################################################

    // CMD writes wait here while the FIFO is full
    assign pready  = access_phase && !(cmd_write && full);
    assign pslverr = access_phase && bad_access;

    assign push      = access_phase && cmd_write && !full;
    assign push_data = alu_pkg::cmd_u'(pwdata);

    // ####################################################################
    // Read data
    // ####################################################################

    always_comb begin
        read_word = '0;
        if (addr_result) begin
            read_word = 32'(result.data);
        end else if (addr_status) begin
            read_word = {29'd0, full, result.carry, result.busy};
        end
    end

    // Sampled in the setup cycle, held through the access cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prdata <= '0;
        end else if (setup_phase) begin
            prdata <= pwrite ? 32'd0 : read_word;
        end
    end

endmodule

// File: source/alu_core_top.sv
`timescale 1ns/1ps

module alu_core_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic             push;
    alu_pkg::cmd_u    push_data;
    logic             full;
    logic             cmd_valid;
    logic             cmd_ready;
    alu_pkg::cmd_u    cmd;
    alu_pkg::result_t result;

    apb_cmd_slave u_apb_cmd_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .full      (full),
        .result    (result),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .push      (push),
        .push_data (push_data)
    );

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .cmd_ready (cmd_ready),
        .full      (full),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    alu_registers u_alu_registers (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .result    (result)
    );

endmodule

// File: tests/cmd_fifo_checker.sv
`timescale 1ns/1ps

module cmd_fifo_checker #(
    parameter int FIFO_DEPTH = 4
) (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          push,
    input logic                          full,
    input logic                          cmd_valid,
    input logic                          cmd_ready,
    input logic [$clog2(FIFO_DEPTH):0]   count
);

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    int fail_count = 0;

    // A push into a full FIFO needs a pop in the same cycle
    push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (push && full) |-> (cmd_valid && cmd_ready))
        else begin
            fail_count++;
            $error("cmd_fifo push while full with no pop");
        end

    // An empty FIFO stays empty until a push arrives
    empty_follows_push: assert property (@(posedge clk) disable iff (!rst_n)
        !cmd_valid |=> (cmd_valid == $past(push)))
        else begin
            fail_count++;
            $error("cmd_fifo empty state does not follow push");
        end

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(FIFO_DEPTH))
        else begin
            fail_count++;
            $error("cmd_fifo count above depth");
        end

    full_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !full)
        else begin
            fail_count++;
            $error("cmd_fifo full right after reset");
        end

endmodule

bind cmd_fifo cmd_fifo_checker #(
    .FIFO_DEPTH (FIFO_DEPTH)
) u_cmd_fifo_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .full      (full),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .count     (count)
);

// File: tests/alu_core_scoreboard.sv
`timescale 1ns/1ps

module alu_core_scoreboard (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    output int          error_count,
    output int          check_count
);

    logic [alu_pkg::DATA_W-1:0] model_regs [alu_pkg::NUM_REGS];
    logic [alu_pkg::DATA_W-1:0] model_last;  // Last READ value
    logic                       model_carry;
    logic                       idle;        // STATUS showed busy low, no CMD since
    int                         errors = 0;
    int                         checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    // ####################################################################
    // Reference model of the register engine
    // ####################################################################

    task automatic apply_cmd(input alu_pkg::cmd_u c);
        logic [alu_pkg::DATA_W-1:0] a;
        logic [alu_pkg::DATA_W-1:0] b;
        logic [alu_pkg::DATA_W:0]   total;
        a = model_regs[c.arith.addr_a];
        b = model_regs[c.arith.addr_b];
        case (c.arith.op)
            alu_pkg::OP_READ:  model_last = a;
            alu_pkg::OP_WRITE: model_regs[c.imm.addr_a] = c.imm.data;
            alu_pkg::OP_ADD: begin
                total       = {1'b0, a} + {1'b0, b};
                model_carry = total[alu_pkg::DATA_W];
                model_regs[c.arith.addr_r] = total[alu_pkg::DATA_W-1:0];
            end
            default: begin
                total       = {1'b0, a} - {1'b0, b};
                model_carry = !total[alu_pkg::DATA_W];  // Set when no borrow
                model_regs[c.arith.addr_r] = total[alu_pkg::DATA_W-1:0];
            end
        endcase
    endtask

    task automatic check_transfer();
        logic exp_err;
        exp_err = !(paddr inside {alu_pkg::ADDR_CMD, alu_pkg::ADDR_RESULT, alu_pkg::ADDR_STATUS})
                  || (pwrite && (paddr != alu_pkg::ADDR_CMD));
        compare("pslverr", 32'(exp_err), 32'(pslverr));
        if (exp_err) begin
            if (!pwrite) begin
                compare("error read data", 32'd0, prdata);
            end
        end else if (pwrite) begin
            apply_cmd(pwdata);
            idle = 1'b0;
        end else if (paddr == alu_pkg::ADDR_RESULT) begin
            if (idle) begin
                compare("RESULT", 32'(model_last), prdata);
            end else begin
                compare("RESULT upper bits", 32'd0, {prdata[31:16], 16'd0});
            end
        end else if (paddr == alu_pkg::ADDR_STATUS) begin
            if (prdata[0]) begin
                compare("STATUS upper bits", 32'd0, {prdata[31:3], 3'd0});
            end else begin
                compare("STATUS", {29'd0, 1'b0, model_carry, 1'b0}, prdata);  // Idle, not full
                idle = 1'b1;
            end
        end else begin
            compare("CMD read data", 32'd0, prdata);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < alu_pkg::NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
            model_last  = '0;
            model_carry = 1'b0;
            idle        = 1'b1;
        end else if (psel && penable && pready) begin
            check_transfer();
        end
    end

endmodule

// File: tests/alu_core_tb.sv
`timescale 1ns/1ps

module alu_core_tb;

    localparam int FIFO_DEPTH = 4;
    localparam int NUM_WR     = 40;
    localparam int NUM_ARITH  = 300;
    localparam int NUM_CHAINS = 20;
    localparam int CHAIN_LEN  = 6;
    localparam int NUM_ERR    = 8;
    localparam int REG_SWEEP  = 3 * alu_pkg::NUM_REGS;  // READ, poll, RESULT per register

    // One poll counted per wait
    localparam int PLANNED_XFERS = 3 * REG_SWEEP + 5 * NUM_WR + 8 * NUM_ARITH
                                 + NUM_CHAINS * (CHAIN_LEN + 4) + 3 * FIFO_DEPTH
                                 + 2 * NUM_ERR + 8;
    localparam int WATCHDOG_CYCLES = 200 * PLANNED_XFERS;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] rdata;
    logic [31:0] rng_state = 32'd42;
    int          error_count;
    int          check_count;

    always #4 clk = ~clk;

    alu_core_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    alu_core_scoreboard sb (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .error_count (error_count),
        .check_count (check_count)
    );

    // ####################################################################
    // Stimulus helpers
    // ####################################################################

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [3:0] rand_reg();
        logic [31:0] r;
        r = next_random();
        return r[7:4];
    endfunction

    function automatic alu_pkg::cmd_u make_imm(input logic [3:0] dest, input logic [15:0] value);
        alu_pkg::cmd_u c;
        c            = '0;
        c.imm.op     = alu_pkg::OP_WRITE;
        c.imm.addr_a = dest;
        c.imm.data   = value;
        return c;
    endfunction

    function automatic alu_pkg::cmd_u make_arith(input alu_pkg::op_t op, input logic [3:0] dest,
                                                 input logic [3:0] a, input logic [3:0] b);
        alu_pkg::cmd_u c;
        c              = '0;
        c.arith.op     = op;
        c.arith.addr_r = dest;
        c.arith.addr_a = a;
        c.arith.addr_b = b;
        return c;
    endfunction

    function automatic alu_pkg::cmd_u make_read(input logic [3:0] a);
        return make_arith(alu_pkg::OP_READ, 4'd0, a, 4'd0);
    endfunction

    function automatic alu_pkg::cmd_u random_cmd();
        logic [31:0] r;
        r = next_random();
        if (r[1:0] == 2'd1) begin
            return make_imm(r[5:2], r[31:16]);
        end
        return make_arith(alu_pkg::op_t'(r[1:0]), r[5:2], r[9:6], r[13:10]);
    endfunction

    // Setup and access on falling edges with pready sampled mid cycle
    task automatic apb_transfer(input logic wr, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
        end
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic issue_cmd(input alu_pkg::cmd_u c);
        apb_transfer(1'b1, alu_pkg::ADDR_CMD, c, rdata);
    endtask

    task automatic read_result();
        apb_transfer(1'b0, alu_pkg::ADDR_RESULT, 32'd0, rdata);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        status = 32'd1;
        while (status[0]) begin
            apb_transfer(1'b0, alu_pkg::ADDR_STATUS, 32'd0, status);
        end
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < alu_pkg::NUM_REGS; i++) begin
            issue_cmd(make_read(4'(i)));
            wait_idle();
            read_result();
        end
    endtask

    // ####################################################################
    // Test sequence
    // ####################################################################

    initial begin
        logic [3:0]  dest;
        logic [31:0] rnd;
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        wait_idle();  // Reset state
        check_all_regs();

        repeat (NUM_WR) begin
            dest = rand_reg();
            rnd  = next_random();
            issue_cmd(make_imm(dest, rnd[15:0]));
            wait_idle();
            issue_cmd(make_read(dest));
            wait_idle();
            read_result();
        end

        repeat (NUM_ARITH) begin
            rnd = next_random();
            if (rnd[0]) begin
                issue_cmd(make_imm(rand_reg(), rnd[31:16]));
            end
            dest = rand_reg();
            issue_cmd(make_arith(rnd[1] ? alu_pkg::OP_SUB : alu_pkg::OP_ADD,
                                 dest, rand_reg(), rand_reg()));
            if (rnd[2]) begin
                issue_cmd(make_read(rand_reg()));
            end
            wait_idle();  // Carry checked on the idle poll
            read_result();
            issue_cmd(make_read(dest));
            wait_idle();
            read_result();
        end

        // Each link reads the previous destination
        repeat (NUM_CHAINS) begin
            dest = rand_reg();
            rnd  = next_random();
            issue_cmd(make_imm(dest, rnd[15:0]));
            repeat (CHAIN_LEN) begin
                rnd = next_random();
                issue_cmd(make_arith(rnd[0] ? alu_pkg::OP_SUB : alu_pkg::OP_ADD,
                                     rnd[7:4], dest, rnd[11:8]));
                dest = rnd[7:4];
            end
            issue_cmd(make_read(dest));
            wait_idle();
            read_result();
        end

        repeat (3 * FIFO_DEPTH) begin
            issue_cmd(random_cmd());
        end
        wait_idle();
        check_all_regs();

        apb_transfer(1'b0, 4'hC, 32'd0, rdata);
        repeat (NUM_ERR) begin
            rnd = next_random();
            apb_transfer(1'b0, {rnd[3:1], 1'b1}, 32'd0, rdata);  // Odd addresses are unmapped
            apb_transfer(1'b1, rnd[4] ? alu_pkg::ADDR_STATUS : alu_pkg::ADDR_RESULT,
                         next_random(), rdata);
        end
        wait_idle();
        read_result();
        check_all_regs();

        repeat (4) @(posedge clk);
        $display("Checks: %0d  Errors: %0d  Assertion failures: %0d", check_count, error_count,
                 dut.u_cmd_fifo.u_cmd_fifo_checker.fail_count);
        if (error_count == 0 && check_count > 0
            && dut.u_cmd_fifo.u_cmd_fifo_checker.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: simulation still running after %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: build.f
source/alu_pkg.sv
source/register_file.sv
source/alu_registers.sv
source/cmd_fifo.sv
source/apb_cmd_slave.sv
source/alu_core_top.sv
tests/cmd_fifo_checker.sv
tests/alu_core_scoreboard.sv
tests/alu_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the ALU core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module alu_core_tb \
    -f build.f \
    -o alu_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/alu_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench reports a failed run in the log
if grep -qF '*** FAILED ***' "$log"; then
    echo "Test run reported failure"
    exit 1
fi

echo "Test run completed without failure"
exit 0
